// ==== sim.f ====
verilog/tti_tx_pkg.sv
verilog/tti_data_if.sv
verilog/tti_queue.sv
verilog/tx_width_conv.sv
verilog/descriptor_tx.sv
verilog/tti_tx_path.sv
tests/tti_tx_path_sva.sv
tests/tti_tx_path_tb.sv

// ==== Bender.yml ====
package:
  name: tti_tx_path

sources:
  - files:
      - verilog/tti_tx_pkg.sv
      - verilog/tti_data_if.sv
      - verilog/tti_queue.sv
      - verilog/tx_width_conv.sv
      - verilog/descriptor_tx.sv
      - verilog/tti_tx_path.sv
  - target: test
    files:
      - tests/tti_tx_path_sva.sv
      - tests/tti_tx_path_tb.sv

// ==== tests/tti_tx_path_tb.sv ====
// Directed testbench for the TTI transmit path, models the bus FSM and scores the byte stream
`timescale 1ns/1ps
`default_nettype none

module tti_tx_path_tb
  import tti_tx_pkg::*;
();

  localparam int unsigned ClkPeriod     = 4;
  localparam int unsigned TimeoutCycles = 4000;  // All tests together stay below 1500

  logic                   clk;
  logic                   rst_n;
  logic                   desc_wvalid;
  logic                   desc_wready;
  logic [TxDescWidth-1:0] desc_wdata;
  logic                   data_wvalid;
  logic                   data_wready;
  logic [TxWordWidth-1:0] data_wdata;
  logic [TxByteWidth-1:0] tx_byte;
  logic                   tx_byte_valid;
  logic                   tx_byte_last;
  logic                   tx_byte_ready;
  logic                   tx_byte_err;

  logic [TxByteWidth-1:0] got_byte [$];  // Bytes taken by the bus model
  bit                     got_last [$];
  int unsigned            errors = 0;
  int unsigned            checks = 0;
  int unsigned            cycles = 0;

  tti_tx_path uut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .desc_wvalid_i   (desc_wvalid),
    .desc_wready_o   (desc_wready),
    .desc_wdata_i    (desc_wdata),
    .data_wvalid_i   (data_wvalid),
    .data_wready_o   (data_wready),
    .data_wdata_i    (data_wdata),
    .tx_byte_o       (tx_byte),
    .tx_byte_valid_o (tx_byte_valid),
    .tx_byte_last_o  (tx_byte_last),
    .tx_byte_ready_i (tx_byte_ready),
    .tx_byte_err_i   (tx_byte_err)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Bus FSM model, records every accepted byte with its last flag
  always @(posedge clk) begin
    if (tx_byte_valid && tx_byte_ready) begin
      got_byte.push_back(tx_byte);
      got_last.push_back(tx_byte_last);
    end
  end

  task automatic check_value(input string test, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("error %s: expected %h, actual %h", test, exp, act);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("%s", what);
    end
  endtask

  task automatic cycle();
    @(posedge clk);
    #1;
  endtask

  // Reserved upper bits get random values, the handler must ignore them
  task automatic write_desc(input int unsigned len);
    logic [TxDescWidth-1:0] word;
    word = $urandom();
    word[TxLenLsb +: TxLenWidth] = TxLenWidth'(len);
    desc_wvalid = 1'b1;
    desc_wdata  = word;
    while (!desc_wready) cycle();
    cycle();
    desc_wvalid = 1'b0;
  endtask

  task automatic push_words(input int unsigned n, ref logic [TxWordWidth-1:0] words [$]);
    repeat (n) begin
      data_wdata  = $urandom();
      data_wvalid = 1'b1;
      words.push_back(data_wdata);
      while (!data_wready) cycle();
      cycle();
      data_wvalid = 1'b0;
    end
  endtask

  // Ready drops in the cycle right after the n-th byte is taken
  task automatic collect_bytes(input int unsigned n, input bit gaps);
    while (got_byte.size() < n) begin
      tx_byte_ready = gaps ? ($urandom_range(2) != 0) : 1'b1;
      cycle();
    end
    tx_byte_ready = 1'b0;
  endtask

  task automatic settle(input int unsigned n);
    tx_byte_ready = 1'b1;  // Any stray byte would be taken and counted
    repeat (n) cycle();
    tx_byte_ready = 1'b0;
  endtask

  // Little-endian bytes of the written words, cut to the descriptor length
  task automatic check_msg(input string test, input int unsigned len,
                           input logic [TxWordWidth-1:0] words [$], input bit ends);
    logic [TxByteWidth-1:0] exp;
    for (int unsigned i = 0; i < len; i++) begin
      exp = TxByteWidth'(words[i / TxBytesPerWord] >> (TxByteWidth * (i % TxBytesPerWord)));
      if (got_byte.size() == 0) begin
        check_true(1'b0, $sformatf("%s: byte %0d was never sent", test, i));
      end else begin
        check_value(test, exp, got_byte.pop_front());
        check_value({test, " last"}, 32'(ends && (i == len - 1)), 32'(got_last.pop_front()));
      end
    end
  endtask

  task automatic test_reset();
    check_value("reset valid", 0, tx_byte_valid);
    check_value("reset last", 0, tx_byte_last);
    check_value("reset desc ready", 0, desc_wready);
    check_value("reset data ready", 0, data_wready);
    cycle();
    check_value("desc ready after reset", 1, desc_wready);
    check_value("data ready after reset", 1, data_wready);
    settle(10);
    check_value("reset bytes", 0, got_byte.size());
  endtask

  task automatic test_whole_words();
    logic [TxWordWidth-1:0] words [$];
    write_desc(8);
    push_words(2, words);
    collect_bytes(8, 1'b0);
    settle(8);
    check_value("whole_words count", 8, got_byte.size());
    check_msg("whole_words", 8, words, 1'b1);
  endtask

  task automatic test_gating();
    logic [TxWordWidth-1:0] words [$];
    write_desc(12);
    push_words(2, words);
    tx_byte_ready = 1'b1;
    repeat (20) begin
      check_true(!tx_byte_valid, "gating: byte valid before the whole message was queued");
      cycle();
    end
    push_words(1, words);
    collect_bytes(12, 1'b0);
    settle(8);
    check_value("gating count", 12, got_byte.size());
    check_msg("gating", 12, words, 1'b1);
  endtask

  task automatic test_partial();
    logic [TxWordWidth-1:0] first [$];
    logic [TxWordWidth-1:0] second [$];
    write_desc(5);
    write_desc(4);
    push_words(2, first);
    push_words(1, second);
    collect_bytes(9, 1'b0);
    settle(8);
    check_value("partial count", 9, got_byte.size());
    check_msg("partial first", 5, first, 1'b1);
    check_msg("partial second", 4, second, 1'b1);
  endtask

  task automatic test_backpressure();
    logic [TxWordWidth-1:0] words [$];
    write_desc(32);
    push_words(8, words);
    collect_bytes(32, 1'b1);
    settle(8);
    check_value("backpressure count", 32, got_byte.size());
    check_msg("backpressure", 32, words, 1'b1);
  endtask

  task automatic test_error_abort();
    logic [TxWordWidth-1:0] words [$];
    logic [TxWordWidth-1:0] fresh [$];
    write_desc(16);
    push_words(4, words);
    collect_bytes(3, 1'b0);
    tx_byte_err = 1'b1;  // Bus reports an error with byte 4 still offered
    cycle();
    tx_byte_err = 1'b0;
    settle(8);
    check_value("abort count", 3, got_byte.size());
    check_msg("abort", 3, words, 1'b0);
    write_desc(4);
    push_words(1, fresh);
    collect_bytes(4, 1'b0);
    settle(8);
    check_value("after_abort count", 4, got_byte.size());
    check_msg("after_abort", 4, fresh, 1'b1);
  endtask

  initial begin
    void'($urandom(32'h5cf5));
    rst_n         = 1'b0;
    desc_wvalid   = 1'b0;
    desc_wdata    = '0;
    data_wvalid   = 1'b0;
    data_wdata    = '0;
    tx_byte_ready = 1'b0;
    tx_byte_err   = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset();
    test_whole_words();
    test_gating();
    test_partial();
    test_backpressure();
    test_error_abort();
    errors += uut.u_descriptor_tx.u_sva.fail_cnt;  // Failed protocol assertions
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    while (cycles < TimeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the tests did not finish within %0d cycles", TimeoutCycles);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/tti_tx_path_sva.sv ====
// Bus-side protocol assertions, bound into each descriptor_tx instance
`timescale 1ns/1ps
`default_nettype none

module tti_tx_path_sva
  import tti_tx_pkg::*;
(
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic [TxByteWidth-1:0] byte_i,
  input logic                   byte_valid_i,
  input logic                   byte_last_i,
  input logic                   byte_ready_i,
  input logic                   byte_err_i,
  input logic                   pending_i,
  input logic                   desc_ready_i
);

  int unsigned fail_cnt = 0;

  stall_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    byte_valid_i && !byte_ready_i && !byte_err_i |=> byte_valid_i && $stable(byte_i))
    else begin
      fail_cnt++;
      $error("byte changed or valid dropped while the bus stalled");
    end

  last_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    byte_last_i |-> byte_valid_i)
    else begin
      fail_cnt++;
      $error("last flag high without a valid byte");
    end

  // A new message needs a new descriptor, which has to wait for the pending one
  no_restart_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pending_i |-> !desc_ready_i)
    else begin
      fail_cnt++;
      $error("new descriptor taken while another message was pending");
    end

  // First sampled cycle out of reset
  reset_idle_a: assert property (@(posedge clk_i) $rose(rst_ni) |-> !byte_valid_i)
    else begin
      fail_cnt++;
      $error("byte valid high right after reset");
    end

endmodule

bind descriptor_tx tti_tx_path_sva u_sva (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .byte_i       (tx_byte_o),
  .byte_valid_i (tx_byte_valid_o),
  .byte_last_i  (tx_byte_last_o),
  .byte_ready_i (tx_byte_ready_i),
  .byte_err_i   (tx_byte_err_i),
  .pending_i    (pending_q),
  .desc_ready_i (desc_rready_o)
);

`default_nettype wire

// ==== verilog/tti_tx_path.sv ====
// Top level of the TTI transmit path, from the software write ports to the bus byte stream
`timescale 1ns/1ps
`default_nettype none

module tti_tx_path
  import tti_tx_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   desc_wvalid_i,
  output logic                   desc_wready_o,
  input  logic [TxDescWidth-1:0] desc_wdata_i,

  input  logic                   data_wvalid_i,
  output logic                   data_wready_o,
  input  logic [TxWordWidth-1:0] data_wdata_i,

  output logic [TxByteWidth-1:0] tx_byte_o,
  output logic                   tx_byte_valid_o,
  output logic                   tx_byte_last_o,
  input  logic                   tx_byte_ready_i,
  input  logic                   tx_byte_err_i
);

  logic                      desc_rvalid;
  logic                      desc_rready;
  logic [TxDescWidth-1:0]    desc_rdata;
  logic                      word_valid;
  logic                      word_ready;
  logic [TxWordWidth-1:0]    word_data;
  logic [TxDataLvlWidth-1:0] data_depth;
  logic                      queue_flush;

  tti_data_if data_if ();

  tti_queue #(
    .Width (TxDescWidth),
    .Depth (TxDescDepth)
  ) u_desc_q (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (desc_wvalid_i),
    .wready_o (desc_wready_o),
    .wdata_i  (desc_wdata_i),
    .rvalid_o (desc_rvalid),
    .rready_i (desc_rready),
    .rdata_o  (desc_rdata),
    .flush_i  (1'b0),        // Descriptors are only consumed
    .depth_o  ()
  );

  tti_queue #(
    .Width (TxWordWidth),
    .Depth (TxDataDepth)
  ) u_data_q (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (data_wvalid_i),
    .wready_o (data_wready_o),
    .wdata_i  (data_wdata_i),
    .rvalid_o (word_valid),
    .rready_i (word_ready),
    .rdata_o  (word_data),
    .flush_i  (queue_flush),
    .depth_o  (data_depth)
  );

  tx_width_conv u_width_conv (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .word_valid_i  (word_valid),
    .word_ready_o  (word_ready),
    .word_i        (word_data),
    .queue_depth_i (data_depth),
    .data          (data_if.conv)
  );

  descriptor_tx u_descriptor_tx (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .desc_rvalid_i   (desc_rvalid),
    .desc_rready_o   (desc_rready),
    .desc_rdata_i    (desc_rdata),
    .data            (data_if.desc),
    .queue_flush_o   (queue_flush),
    .tx_byte_o       (tx_byte_o),
    .tx_byte_last_o  (tx_byte_last_o),
    .tx_byte_valid_o (tx_byte_valid_o),
    .tx_byte_ready_i (tx_byte_ready_i),
    .tx_byte_err_i   (tx_byte_err_i)
  );

endmodule

`default_nettype wire

// ==== verilog/descriptor_tx.sv ====
// TX descriptor handler, gates each message on queued data and feeds its bytes to the bus FSM
`timescale 1ns/1ps
`default_nettype none

module descriptor_tx
  import tti_tx_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   desc_rvalid_i,
  output logic                   desc_rready_o,
  input  logic [TxDescWidth-1:0] desc_rdata_i,

  tti_data_if.desc               data,
  output logic                   queue_flush_o,

  output logic [TxByteWidth-1:0] tx_byte_o,
  output logic                   tx_byte_last_o,
  output logic                   tx_byte_valid_o,
  input  logic                   tx_byte_ready_i,
  input  logic                   tx_byte_err_i
);

  logic                  desc_valid_q;
  logic [TxLenWidth-1:0] len_q;
  logic [TxLenWidth-1:0] words_needed;
  logic [TxLenWidth-1:0] byte_cnt_q;    // Bytes still to send
  logic                  pending_q;
  logic                  tx_start;
  logic                  zero_len;
  logic                  byte_accept;
  logic                  normal_end;
  logic                  err_end;

  assign desc_rready_o = !desc_valid_q;

  // Length rounded up to whole words
  assign words_needed = (len_q >> TxByteIdxWidth) +
                        TxLenWidth'(|len_q[TxByteIdxWidth-1:0]);

  // A message larger than the data queue can never start
  assign zero_len = desc_valid_q && !pending_q && (len_q == '0);
  assign tx_start = desc_valid_q && !pending_q && (len_q != '0) &&
                    (TxLenWidth'(data.depth) >= words_needed);

  assign tx_byte_valid_o = pending_q && data.rvalid;
  assign tx_byte_last_o  = tx_byte_valid_o && (byte_cnt_q == TxLenWidth'(1));
  assign tx_byte_o       = data.rdata;
  assign byte_accept     = tx_byte_valid_o && tx_byte_ready_i;
  assign data.rready     = byte_accept;

  assign normal_end = tx_byte_last_o && tx_byte_ready_i;
  assign err_end    = pending_q && tx_byte_err_i;

  // Leftover bytes of the final word always go, the queue only on abort
  assign data.flush    = normal_end || err_end;
  assign queue_flush_o = err_end;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      desc_valid_q <= 1'b0;
    end else if (normal_end || err_end || zero_len) begin
      desc_valid_q <= 1'b0;
    end else if (desc_rvalid_i && desc_rready_o) begin
      desc_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (desc_rvalid_i && desc_rready_o) begin
      len_q <= desc_rdata_i[TxLenLsb +: TxLenWidth];  // Reserved bits dropped
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q  <= 1'b0;
      byte_cnt_q <= '0;
    end else if (normal_end || err_end) begin
      pending_q  <= 1'b0;
      byte_cnt_q <= '0;
    end else if (tx_start) begin
      pending_q  <= 1'b1;
      byte_cnt_q <= len_q;
    end else if (byte_accept) begin
      byte_cnt_q <= byte_cnt_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/tx_width_conv.sv ====
// Unpacks TX data words into bytes for the descriptor handler, lowest byte first
`timescale 1ns/1ps
`default_nettype none

module tx_width_conv
  import tti_tx_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic                      word_valid_i,
  output logic                      word_ready_o,
  input  logic [TxWordWidth-1:0]    word_i,
  input  logic [TxDataLvlWidth-1:0] queue_depth_i,

  tti_data_if.conv                  data
);

  logic [TxWordWidth-1:0]    word_q;
  logic                      held_q;      // word_q carries unsent bytes
  logic [TxByteIdxWidth-1:0] byte_idx_q;
  logic                      byte_take;
  logic                      word_done;   // Final byte of the held word goes out
  logic                      load;

  assign byte_take = held_q && data.rready;
  assign word_done = byte_take && (byte_idx_q == TxByteIdxWidth'(TxBytesPerWord - 1));

  // Refill when empty or when the held word drains, never while flushing
  assign word_ready_o = (!held_q || word_done) && !data.flush;
  assign load         = word_valid_i && word_ready_o;

  assign data.rvalid = held_q;
  assign data.rdata  = word_q[byte_idx_q * TxByteWidth +: TxByteWidth];
  assign data.depth  = queue_depth_i + TxDataLvlWidth'(held_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q     <= 1'b0;
      byte_idx_q <= '0;
    end else if (data.flush) begin
      held_q     <= 1'b0;
      byte_idx_q <= '0;
    end else if (load) begin
      held_q     <= 1'b1;
      byte_idx_q <= '0;
    end else if (word_done) begin
      held_q     <= 1'b0;  // Queue ran dry
      byte_idx_q <= '0;
    end else if (byte_take) begin
      byte_idx_q <= byte_idx_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      word_q <= word_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/tti_queue.sv ====
// Synchronous FIFO with fill level, instantiated for TX descriptors and TX data words
`timescale 1ns/1ps
`default_nettype none

module tti_queue
  import tti_tx_pkg::*;
#(
  parameter int unsigned Width = 32,
  parameter int unsigned Depth = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic                      wvalid_i,
  output logic                      wready_o,
  input  logic [Width-1:0]          wdata_i,

  output logic                      rvalid_o,
  input  logic                      rready_i,
  output logic [Width-1:0]          rdata_o,

  input  logic                      flush_i,
  output logic [TxDataLvlWidth-1:0] depth_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;

  logic [Width-1:0]          mem_q [Depth];
  logic [PtrWidth-1:0]       wptr_q;
  logic [PtrWidth-1:0]       rptr_q;
  logic [TxDataLvlWidth-1:0] count_q;
  logic                      ready_q;  // Set once out of reset
  logic                      push;
  logic                      pop;

  assign wready_o = ready_q && (count_q != TxDataLvlWidth'(Depth));
  assign rvalid_o = (count_q != '0);
  assign rdata_o  = mem_q[rptr_q];
  assign depth_o  = count_q;

  // A flush wins over both sides, so a write in that cycle is lost
  assign push = wvalid_i && wready_o && !flush_i;
  assign pop  = rvalid_o && rready_i && !flush_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_q <= 1'b0;
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      ready_q <= 1'b1;
      if (flush_i) begin
        wptr_q  <= '0;
        rptr_q  <= '0;
        count_q <= '0;
      end else begin
        if (push) begin
          wptr_q <= (wptr_q == PtrWidth'(Depth - 1)) ? '0 : wptr_q + 1'b1;
        end
        if (pop) begin
          rptr_q <= (rptr_q == PtrWidth'(Depth - 1)) ? '0 : rptr_q + 1'b1;
        end
        case ({push, pop})
          2'b10:   count_q <= count_q + 1'b1;
          2'b01:   count_q <= count_q - 1'b1;
          default: count_q <= count_q;  // Idle or push and pop together
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/tti_data_if.sv ====
// Byte stream and data level from the width converter to the descriptor handler
`timescale 1ns/1ps
`default_nettype none

interface tti_data_if
  import tti_tx_pkg::*;
();

  logic                      rvalid;  // Converter holds a byte
  logic                      rready;  // Byte taken by the bus
  logic [TxByteWidth-1:0]    rdata;
  logic [TxDataLvlWidth-1:0] depth;   // Queued words plus the held one
  logic                      flush;   // Drop the word held in the converter

  modport conv (
    output rvalid, rdata, depth,
    input  rready, flush
  );

  modport desc (
    input  rvalid, rdata, depth,
    output rready, flush
  );

endinterface

`default_nettype wire

// ==== verilog/tti_tx_pkg.sv ====
// Shared widths, queue depths and descriptor field positions for the TTI transmit path
`default_nettype none

package tti_tx_pkg;

  localparam int unsigned TxWordWidth = 32;  // Data queue word
  localparam int unsigned TxDescWidth = 32;  // TX descriptor word
  localparam int unsigned TxByteWidth = 8;   // Byte handed to the bus FSM

  localparam int unsigned TxDataDepth = 64;  // Data queue, in words
  localparam int unsigned TxDescDepth = 4;   // Descriptor queue, in descriptors

  // Fill level must be able to represent a completely full data queue
  localparam int unsigned TxDataLvlWidth = $clog2(TxDataDepth + 1);

  localparam int unsigned TxBytesPerWord = TxWordWidth / TxByteWidth;
  localparam int unsigned TxByteIdxWidth = $clog2(TxBytesPerWord);

  // Descriptor layout, upper half is reserved
  localparam int unsigned TxLenWidth = 16;
  localparam int unsigned TxLenLsb = 0;

endpackage

`default_nettype wire
